// ==== hdl/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0] strobe_t;
    typedef logic [3:0] alu_op_t;

    typedef enum logic [4:0] {
        op_add, op_sub, op_slt, op_sltu, op_and, op_or, op_xor, op_nor,
        op_sll, op_srl, op_sra, op_lui,
        op_div, op_divu, op_mod, op_modu,
        op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu,
        op_st_b, op_st_h, op_st_w
    } ex_op_t;

    // alu function codes
    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_slt  = 4'd2;
    localparam alu_op_t alu_sltu = 4'd3;
    localparam alu_op_t alu_and  = 4'd4;
    localparam alu_op_t alu_or   = 4'd5;
    localparam alu_op_t alu_xor  = 4'd6;
    localparam alu_op_t alu_nor  = 4'd7;
    localparam alu_op_t alu_sll  = 4'd8;
    localparam alu_op_t alu_srl  = 4'd9;
    localparam alu_op_t alu_sra  = 4'd10;
    localparam alu_op_t alu_lui  = 4'd11;

    // access width of a memory operation
    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2
    } mem_size_t;

    function automatic logic is_div(ex_op_t op);
        return op inside {op_div, op_divu, op_mod, op_modu};
    endfunction

    function automatic logic is_load(ex_op_t op);
        return op inside {op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu};
    endfunction

    function automatic logic is_store(ex_op_t op);
        return op inside {op_st_b, op_st_h, op_st_w};
    endfunction

    function automatic mem_size_t op_size(ex_op_t op);
        if (op inside {op_ld_b, op_ld_bu, op_st_b})
            return size_b;
        else if (op inside {op_ld_h, op_ld_hu, op_st_h})
            return size_h;
        else
            return size_w;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import ex_pkg::*;
(
    input  alu_op_t op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            alu_add:
                result = src1 + src2;
            alu_sub:
                result = src1 - src2;
            alu_slt:
                result = {31'd0, $signed(src1) < $signed(src2)};
            alu_sltu:
                result = {31'd0, src1 < src2};
            alu_and:
                result = src1 & src2;
            alu_or:
                result = src1 | src2;
            alu_xor:
                result = src1 ^ src2;
            alu_nor:
                result = ~(src1 | src2);
            alu_sll:
                result = src1 << shamt;
            alu_srl:
                result = src1 >> shamt;
            alu_sra:
                result = word_t'($signed(src1) >>> shamt);
            // upper immediate arrives unshifted in src2
            alu_lui:
                result = src2 << 12;
            default:
                result = src1 + src2;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module divider
    import ex_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  logic  is_signed,
    input  logic  want_rem,
    input  word_t dividend,
    input  word_t divisor,
    output logic  busy,
    output logic  done,
    output word_t result
);

    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_fix
    } div_state_t;

    div_state_t state;
    logic [4:0] count;
    word_t quot;
    word_t rem;
    word_t dvs;
    logic neg_q;
    logic neg_r;
    logic rem_sel;
    logic [32:0] shifted;
    logic [32:0] trial;

    // one restoring step
    assign shifted = {rem, quot[31]};
    assign trial = shifted - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= div_idle;
            count <= 5'd0;
        end else begin
            case (state)
                div_idle: begin
                    if (start) begin
                        state <= div_run;
                        count <= 5'd0;
                    end
                end
                div_run: begin
                    count <= count + 5'd1;
                    if (count == 5'd31)
                        state <= div_fix;
                end
                default:
                    state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == div_idle && start) begin
            quot <= (is_signed && dividend[31]) ? -dividend : dividend;
            dvs <= (is_signed && divisor[31]) ? -divisor : divisor;
            rem <= '0;
            // zero divisor keeps the all-ones quotient unsigned
            neg_q <= is_signed && (dividend[31] ^ divisor[31]) && (divisor != '0);
            neg_r <= is_signed && dividend[31];
            rem_sel <= want_rem;
        end else if (state == div_run) begin
            if (!trial[32]) begin
                rem <= trial[31:0];
                quot <= {quot[30:0], 1'b1};
            end else begin
                rem <= shifted[31:0];
                quot <= {quot[30:0], 1'b0};
            end
        end
    end

    assign busy = (state != div_idle);
    assign done = (state == div_fix);

    // sign fix-up, held stable until the next start
    always_comb begin
        if (rem_sel)
            result = neg_r ? -rem : rem;
        else
            result = neg_q ? -quot : quot;
    end

endmodule

`default_nettype wire

// ==== hdl/mem_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_align
    import ex_pkg::*;
(
    input  ex_op_t  op,
    input  word_t   addr,
    input  word_t   store_data,
    input  word_t   load_word,
    output strobe_t sel,
    output word_t   write_data,
    output logic    misaligned,
    output word_t   load_result
);

    mem_size_t size;
    word_t lane;

    assign size = op_size(op);

    always_comb begin
        case (size)
            size_b: begin
                sel = strobe_t'(4'b0001 << addr[1:0]);
                write_data = {4{store_data[7:0]}};
            end
            size_h: begin
                sel = addr[1] ? 4'b1100 : 4'b0011;
                write_data = {2{store_data[15:0]}};
            end
            default: begin
                sel = 4'b1111;
                write_data = store_data;
            end
        endcase
    end

    assign misaligned = (is_load(op) || is_store(op))
        && ((size == size_h && addr[0]) || (size == size_w && addr[1:0] != 2'b00));

    // addressed lane moved down to bit 0
    assign lane = load_word >> {addr[1:0], 3'b000};

    always_comb begin
        case (op)
            op_ld_b:  load_result = {{24{lane[7]}}, lane[7:0]};
            op_ld_bu: load_result = {24'd0, lane[7:0]};
            op_ld_h:  load_result = {{16{lane[15]}}, lane[15:0]};
            op_ld_hu: load_result = {16'd0, lane[15:0]};
            default:  load_result = load_word;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  ex_op_t  in_op,
    input  word_t   in_src1,
    input  word_t   in_src2,
    input  word_t   in_store_data,
    output logic    in_ready,
    output logic    out_valid,
    input  logic    out_ready,
    output word_t   out_result,
    output logic    out_except,
    output logic    wb_cyc,
    output logic    wb_stb,
    output logic    wb_we,
    output word_t   wb_adr,
    output strobe_t wb_sel,
    output word_t   wb_dat_w,
    input  word_t   wb_dat_r,
    input  logic    wb_ack
);

    logic valid_q;
    ex_op_t op_q;
    word_t src1_q;
    word_t src2_q;
    word_t store_data_q;
    logic div_issued;
    logic div_ready;
    logic mem_acked;
    word_t mem_data_q;
    alu_op_t alu_fn;
    word_t alu_result;
    word_t div_result;
    word_t load_word;
    word_t load_result;
    logic misaligned;
    logic div_busy;
    logic div_done;
    logic div_start;
    logic mem_go;
    logic ready_go;
    logic out_allow;
    logic take_in;
    word_t result_sel;

    function automatic alu_op_t alu_code(ex_op_t op);
        case (op)
            op_sub:  return alu_sub;
            op_slt:  return alu_slt;
            op_sltu: return alu_sltu;
            op_and:  return alu_and;
            op_or:   return alu_or;
            op_xor:  return alu_xor;
            op_nor:  return alu_nor;
            op_sll:  return alu_sll;
            op_srl:  return alu_srl;
            op_sra:  return alu_sra;
            op_lui:  return alu_lui;
            // memory ops use the sum as address
            default: return alu_add;
        endcase
    endfunction

    assign alu_fn = alu_code(op_q);

    alu alu_inst (
        .op     (alu_fn),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (alu_result)
    );

    assign div_start = valid_q && is_div(op_q) && !div_issued && !div_busy;

    divider divider_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (op_q inside {op_div, op_mod}),
        .want_rem  (op_q inside {op_mod, op_modu}),
        .dividend  (src1_q),
        .divisor   (src2_q),
        .busy      (div_busy),
        .done      (div_done),
        .result    (div_result)
    );

    // read data is kept once acked, in case the output is stalled
    assign load_word = mem_acked ? mem_data_q : wb_dat_r;

    mem_align mem_align_inst (
        .op          (op_q),
        .addr        (alu_result),
        .store_data  (store_data_q),
        .load_word   (load_word),
        .sel         (wb_sel),
        .write_data  (wb_dat_w),
        .misaligned  (misaligned),
        .load_result (load_result)
    );

    assign mem_go = (is_load(op_q) || is_store(op_q)) && !misaligned;

    assign wb_cyc = valid_q && mem_go && !mem_acked;
    assign wb_stb = wb_cyc;
    assign wb_we = is_store(op_q);
    assign wb_adr = alu_result;

    always_comb begin
        if (is_div(op_q))
            ready_go = div_done || div_ready;
        else if (mem_go)
            ready_go = (wb_cyc && wb_ack) || mem_acked;
        else
            ready_go = 1'b1;
    end

    assign out_allow = !out_valid || out_ready;
    assign in_ready = out_allow && (!valid_q || ready_go);
    assign take_in = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            div_issued <= 1'b0;
            div_ready <= 1'b0;
            mem_acked <= 1'b0;
        end else begin
            if (in_ready)
                valid_q <= in_valid;
            if (take_in) begin
                div_issued <= 1'b0;
                div_ready <= 1'b0;
                mem_acked <= 1'b0;
            end else begin
                if (div_start)
                    div_issued <= 1'b1;
                if (div_done)
                    div_ready <= 1'b1;
                if (wb_cyc && wb_ack)
                    mem_acked <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_in) begin
            op_q <= in_op;
            src1_q <= in_src1;
            src2_q <= in_src2;
            store_data_q <= in_store_data;
        end
        if (wb_cyc && wb_ack)
            mem_data_q <= wb_dat_r;
    end

    // stores and misaligned accesses report the address
    always_comb begin
        if (is_div(op_q))
            result_sel = div_result;
        else if (is_load(op_q) && !misaligned)
            result_sel = load_result;
        else
            result_sel = alu_result;
    end

    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else if (out_allow)
            out_valid <= valid_q && ready_go;
    end

    always_ff @(posedge clk) begin
        if (out_allow && valid_q && ready_go) begin
            out_result <= result_sel;
            out_except <= misaligned;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import ex_pkg::*;
#(
    parameter int ram_words = 256
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  word_t   adr,
    input  strobe_t sel,
    input  word_t   dat_w,
    output word_t   dat_r,
    output logic    ack
);

    localparam int aw = $clog2(ram_words);

    word_t mem [ram_words];
    logic [aw-1:0] index;
    logic access;

    assign index = adr[aw+1:2];
    // first cycle of a request, ack follows one cycle later
    assign access = cyc && stb && !ack;

    always_ff @(posedge clk) begin
        if (reset)
            ack <= 1'b0;
        else
            ack <= access;
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_r <= mem[index];
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (sel[i])
                        mem[index][8*i +: 8] <= dat_w[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ex_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_top
    import ex_pkg::*;
#(
    parameter int ram_words = 256
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   in_valid,
    input  ex_op_t in_op,
    input  word_t  in_src1,
    input  word_t  in_src2,
    input  word_t  in_store_data,
    output logic   in_ready,
    output logic   out_valid,
    input  logic   out_ready,
    output word_t  out_result,
    output logic   out_except
);

    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    word_t wb_adr;
    strobe_t wb_sel;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic wb_ack;

    ex_stage ex_stage_inst (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_src1       (in_src1),
        .in_src2       (in_src2),
        .in_store_data (in_store_data),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_result    (out_result),
        .out_except    (out_except),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_sel        (wb_sel),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack)
    );

    data_ram #(
        .ram_words (ram_words)
    ) data_ram_inst (
        .clk   (clk),
        .reset (reset),
        .cyc   (wb_cyc),
        .stb   (wb_stb),
        .we    (wb_we),
        .adr   (wb_adr),
        .sel   (wb_sel),
        .dat_w (wb_dat_w),
        .dat_r (wb_dat_r),
        .ack   (wb_ack)
    );

endmodule

`default_nettype wire

// ==== verification/ex_top_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_top_properties
    import ex_pkg::*;
(
    input wire logic    clk,
    input wire logic    reset,
    input wire logic    in_ready,
    input wire logic    out_valid,
    input wire logic    out_ready,
    input wire word_t   out_result,
    input wire logic    wb_cyc,
    input wire logic    wb_stb,
    input wire logic    wb_ack,
    input wire word_t   wb_adr,
    input wire strobe_t wb_sel
);

    // ack only answers a live request
    ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> wb_cyc && wb_stb)
        else $error("wb_ack outside a bus cycle");

    // request held until the slave acks
    bus_stable: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_sel))
        else $error("bus request changed before ack");

    result_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else $error("output changed under back-pressure");

    // no new operation while a bus cycle waits for ack
    no_allow_in: assert property (@(posedge clk) disable iff (reset)
        wb_cyc && !wb_ack |-> !in_ready)
        else $error("in_ready high during an unacked bus cycle");

endmodule

bind ex_stage ex_top_properties ex_top_properties_inst (
    .clk        (clk),
    .reset      (reset),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .wb_adr     (wb_adr),
    .wb_sel     (wb_sel)
);

`default_nettype wire

// ==== verification/ex_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_top_tb
    import ex_pkg::*;
;

    typedef struct {
        ex_op_t op;
        word_t  src1;
        word_t  src2;
        word_t  store_data;
        word_t  result;
        logic   except;
    } row_t;

    logic   clk;
    logic   reset;
    logic   in_valid;
    ex_op_t in_op;
    word_t  in_src1;
    word_t  in_src2;
    word_t  in_store_data;
    logic   in_ready;
    logic   out_valid;
    logic   out_ready;
    word_t  out_result;
    logic   out_except;

    row_t table_q[$];
    int row_idx;
    int checks;
    int errors;
    int taken;
    int cycles;
    int cycle_limit;

    ex_top #(
        .ram_words (256)
    ) ex_top_inst (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_src1       (in_src1),
        .in_src2       (in_src2),
        .in_store_data (in_store_data),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_result    (out_result),
        .out_except    (out_except)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_row(input ex_op_t op, input word_t src1, input word_t src2,
                           input word_t store_data, input word_t result, input logic except);
        row_t r;
        r.op = op;
        r.src1 = src1;
        r.src2 = src2;
        r.store_data = store_data;
        r.result = result;
        r.except = except;
        table_q.push_back(r);
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %s row %0d got %h expected %h", name, row_idx, actual, expected);
        end
    endtask

    // one operation in flight at a time and its output taken when out_ready allows
    task automatic apply_row(input row_t r);
        in_valid <= 1'b1;
        in_op <= r.op;
        in_src1 <= r.src1;
        in_src2 <= r.src2;
        in_store_data <= r.store_data;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        while (!(out_valid && out_ready))
            @(negedge clk);
        check_value("out_result", out_result, r.result);
        check_value("out_except", {31'd0, out_except}, {31'd0, r.except});
        @(posedge clk);
    endtask

    task automatic build_table();
        // alu
        add_row(op_add,  32'h0000_0005, 32'h0000_0007, 32'h0, 32'h0000_000C, 1'b0);
        add_row(op_add,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0, 32'h0000_0000, 1'b0);
        add_row(op_sub,  32'h0000_0003, 32'h0000_0005, 32'h0, 32'hFFFF_FFFE, 1'b0);
        add_row(op_slt,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0, 32'h0000_0001, 1'b0);
        add_row(op_sltu, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0, 32'h0000_0000, 1'b0);
        add_row(op_slt,  32'h0000_0001, 32'h8000_0000, 32'h0, 32'h0000_0000, 1'b0);
        add_row(op_sltu, 32'h0000_0001, 32'h8000_0000, 32'h0, 32'h0000_0001, 1'b0);
        add_row(op_and,  32'hF0F0_1234, 32'h0FF0_FF00, 32'h0, 32'h00F0_1200, 1'b0);
        add_row(op_or,   32'hF0F0_0000, 32'h0F00_00FF, 32'h0, 32'hFFF0_00FF, 1'b0);
        add_row(op_xor,  32'hAAAA_5555, 32'hFFFF_0000, 32'h0, 32'h5555_5555, 1'b0);
        add_row(op_nor,  32'h0000_FF00, 32'h00FF_0000, 32'h0, 32'hFF00_00FF, 1'b0);
        add_row(op_sll,  32'h0000_0001, 32'h0000_001F, 32'h0, 32'h8000_0000, 1'b0);
        // only the low five bits count as shift amount
        add_row(op_sll,  32'h0000_0003, 32'h0000_0024, 32'h0, 32'h0000_0030, 1'b0);
        add_row(op_srl,  32'h8000_0000, 32'h0000_0004, 32'h0, 32'h0800_0000, 1'b0);
        add_row(op_sra,  32'h8000_0000, 32'h0000_0004, 32'h0, 32'hF800_0000, 1'b0);
        add_row(op_lui,  32'hDEAD_BEEF, 32'h0001_2345, 32'h0, 32'h1234_5000, 1'b0);
        // divider
        add_row(op_div,  32'h0000_0064, 32'h0000_0007, 32'h0, 32'h0000_000E, 1'b0);
        add_row(op_mod,  32'h0000_0064, 32'h0000_0007, 32'h0, 32'h0000_0002, 1'b0);
        add_row(op_div,  32'hFFFF_FF9C, 32'h0000_0007, 32'h0, 32'hFFFF_FFF2, 1'b0);
        add_row(op_mod,  32'hFFFF_FF9C, 32'h0000_0007, 32'h0, 32'hFFFF_FFFE, 1'b0);
        add_row(op_div,  32'h0000_0064, 32'hFFFF_FFF9, 32'h0, 32'hFFFF_FFF2, 1'b0);
        add_row(op_mod,  32'h0000_0064, 32'hFFFF_FFF9, 32'h0, 32'h0000_0002, 1'b0);
        add_row(op_divu, 32'hFFFF_FFFF, 32'h0000_0010, 32'h0, 32'h0FFF_FFFF, 1'b0);
        add_row(op_modu, 32'hFFFF_FFFF, 32'h0000_0010, 32'h0, 32'h0000_000F, 1'b0);
        add_row(op_div,  32'h0000_0005, 32'h0000_0000, 32'h0, 32'hFFFF_FFFF, 1'b0);
        add_row(op_mod,  32'hFFFF_FFFB, 32'h0000_0000, 32'h0, 32'hFFFF_FFFB, 1'b0);
        add_row(op_divu, 32'h0000_0007, 32'h0000_0000, 32'h0, 32'hFFFF_FFFF, 1'b0);
        add_row(op_div,  32'h8000_0000, 32'hFFFF_FFFF, 32'h0, 32'h8000_0000, 1'b0);
        add_row(op_mod,  32'h8000_0000, 32'hFFFF_FFFF, 32'h0, 32'h0000_0000, 1'b0);
        // word store overlaid by byte and halfword stores leaves 0xBEEFA544 at 0x100
        add_row(op_st_w, 32'h0000_0100, 32'h0, 32'h1122_3344, 32'h0000_0100, 1'b0);
        add_row(op_st_b, 32'h0000_0100, 32'h1, 32'h0000_00A5, 32'h0000_0101, 1'b0);
        add_row(op_st_h, 32'h0000_0100, 32'h2, 32'h0000_BEEF, 32'h0000_0102, 1'b0);
        add_row(op_ld_w,  32'h0000_0100, 32'h0, 32'h0, 32'hBEEF_A544, 1'b0);
        add_row(op_ld_b,  32'h0000_0100, 32'h1, 32'h0, 32'hFFFF_FFA5, 1'b0);
        add_row(op_ld_bu, 32'h0000_0100, 32'h1, 32'h0, 32'h0000_00A5, 1'b0);
        add_row(op_ld_b,  32'h0000_0100, 32'h0, 32'h0, 32'h0000_0044, 1'b0);
        add_row(op_ld_bu, 32'h0000_0100, 32'h3, 32'h0, 32'h0000_00BE, 1'b0);
        add_row(op_ld_h,  32'h0000_0100, 32'h2, 32'h0, 32'hFFFF_BEEF, 1'b0);
        add_row(op_ld_hu, 32'h0000_0100, 32'h2, 32'h0, 32'h0000_BEEF, 1'b0);
        add_row(op_ld_h,  32'h0000_0100, 32'h0, 32'h0, 32'hFFFF_A544, 1'b0);
        add_row(op_st_w, 32'h0000_0200, 32'h4, 32'h8001_7FFE, 32'h0000_0204, 1'b0);
        add_row(op_ld_h,  32'h0000_0200, 32'h4, 32'h0, 32'h0000_7FFE, 1'b0);
        add_row(op_ld_h,  32'h0000_0200, 32'h6, 32'h0, 32'hFFFF_8001, 1'b0);
        add_row(op_ld_hu, 32'h0000_0200, 32'h6, 32'h0, 32'h0000_8001, 1'b0);
        add_row(op_ld_b,  32'h0000_0200, 32'h4, 32'h0, 32'hFFFF_FFFE, 1'b0);
        add_row(op_ld_bu, 32'h0000_0200, 32'h7, 32'h0, 32'h0000_0080, 1'b0);
        // misaligned accesses report the address and leave memory alone
        add_row(op_ld_h, 32'h0000_0100, 32'h1, 32'h0, 32'h0000_0101, 1'b1);
        add_row(op_ld_w, 32'h0000_0100, 32'h2, 32'h0, 32'h0000_0102, 1'b1);
        add_row(op_st_h, 32'h0000_0100, 32'h3, 32'h0000_DEAD, 32'h0000_0103, 1'b1);
        add_row(op_st_w, 32'h0000_0100, 32'h1, 32'hDEAD_BEEF, 32'h0000_0101, 1'b1);
        add_row(op_ld_w, 32'h0000_0100, 32'h0, 32'h0, 32'hBEEF_A544, 1'b0);
        add_row(op_add,  32'h0000_0010, 32'h0000_0020, 32'h0, 32'h0000_0030, 1'b0);
    endtask

    // random back-pressure
    initial begin
        void'($urandom(12));
        forever begin
            @(posedge clk);
            out_ready <= ($urandom % 4) != 0;
        end
    end

    // output taken at the next rising edge
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready)
            taken++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles, stuck at row %0d",
                     cycle_limit, row_idx);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        checks = 0;
        errors = 0;
        taken = 0;
        cycles = 0;
        row_idx = 0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_op = op_add;
        in_src1 = '0;
        in_src2 = '0;
        in_store_data = '0;
        out_ready = 1'b0;
        build_table();
        cycle_limit = table_q.size() * 60;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < table_q.size(); i++) begin
            row_idx = i;
            apply_row(table_q[i]);
        end
        // let any duplicate result show up
        repeat (4) @(posedge clk);
        if (taken != table_q.size()) begin
            errors++;
            $display("wrong number of results taken: %0d for %0d operations",
                     taken, table_q.size());
        end
        $display("checks %0d, errors %0d, results %0d", checks, errors, taken);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/ex_pkg.sv
hdl/alu.sv
hdl/divider.sv
hdl/mem_align.sv
hdl/ex_stage.sv
hdl/data_ram.sv
hdl/ex_top.sv
verification/ex_top_properties.sv
verification/ex_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ex_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module ex_top_tb \
        -f sources.f -Mdir obj_dir; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vex_top_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
